/* logic/noc_cfg_params.svh */
// *********************************************************************
// bus widths, version label and mailbox depth of the ni register port
// register address map and region codes of the upper address byte
// *********************************************************************
`ifndef NOC_CFG_PARAMS_SVH
`define NOC_CFG_PARAMS_SVH

// host bus widths
`define AXI_DATA_WIDTH     32
`define AXI_ADDR_WIDTH     16

`define NI_VERSION_LABEL   32'h0001_0002  // major 1, minor 2
`define NI_MBOX_DEPTH      4              // mailbox entries

// csr region, offsets inside region 0x00
`define NI_CSR_VERSION     16'h0000       // ro
`define NI_CSR_ROUTER_X    16'h0004       // ro
`define NI_CSR_ROUTER_Y    16'h0008       // ro
`define NI_CSR_IRQ_MASK    16'h000C       // rw, bit 0 only
`define NI_CSR_MBOX_STATUS 16'h0010       // ro, entry count

// mailbox data port, push on write and pop on read
`define NI_MBOX_DATA       16'h0100

// upper address byte
`define NI_REGION_CSR      8'h00
`define NI_REGION_MBOX     8'h01

`endif

/* logic/noc_bus_pkg.sv */
// *********************************************************************
// host bus types of the ni register port
// address and data words, request and response structs
// *********************************************************************
`include "noc_cfg_params.svh"

package noc_bus_pkg;

  // ******************************************************************
  // plain words
  // ******************************************************************
  typedef logic [`AXI_ADDR_WIDTH-1:0] axi_addr_t;  // byte address
  typedef logic [`AXI_DATA_WIDTH-1:0] axi_data_t;  // full word only

  // ******************************************************************
  // access structs
  // ******************************************************************

  // one host access, 49 bits
  typedef struct packed {
    logic      rd_or_wr;  // 1 = write, 0 = read
    axi_addr_t addr;
    axi_data_t wdata;     // ignored on reads
  } csr_req_t;

  // one response, 33 bits
  typedef struct packed {
    axi_data_t rdata;     // zero on writes and errors
    logic      error;
  } csr_rsp_t;

endpackage

/* logic/noc_csr_pkg.sv */
// *********************************************************************
// internal types of the ni register block
// target select, controller states, mailbox count, router id, mask
// *********************************************************************
`include "noc_cfg_params.svh"

package noc_csr_pkg;

  // ******************************************************************
  // controller
  // ******************************************************************

  // decoded target of one access
  typedef enum logic [1:0] {
    TGT_CSR  = 2'd0,  // id, mask and status registers
    TGT_MBOX = 2'd1,  // mailbox data port
    TGT_NONE = 2'd2   // unmapped, answered by the controller
  } target_sel_t;

  // access fsm
  typedef enum logic {
    ST_IDLE = 1'b0,   // ready, waiting for valid
    ST_RESP = 1'b1    // response strobe cycle
  } access_state_t;

  // ******************************************************************
  // register block
  // ******************************************************************
  typedef logic [$clog2(`NI_MBOX_DEPTH+1)-1:0] mbox_count_t;  // 0 .. depth
  typedef logic [7:0]                          router_id_t;   // one mesh axis
  typedef logic [0:0]                          irq_mask_t;

endpackage

/* logic/ni_access_ctrl.sv */
// *********************************************************************
// ni access controller
// region decode, two-state access fsm, target strobes, response mux
// *********************************************************************
`include "noc_cfg_params.svh"

module ni_access_ctrl (
  input  logic                  clk_axi,
  input  logic                  arst_axi,
  // host request side
  input  logic                  valid,
  output logic                  ready,
  input  noc_bus_pkg::csr_req_t req,
  // towards the targets
  output noc_bus_pkg::csr_req_t tgt_req,
  output logic                  csr_rd,
  output logic                  csr_wr,
  output logic                  mbox_rd,
  output logic                  mbox_wr,
  input  noc_bus_pkg::csr_rsp_t csr_rsp,
  input  noc_bus_pkg::csr_rsp_t mbox_rsp,
  // host response side
  output noc_bus_pkg::csr_rsp_t rsp,
  output logic                  rsp_valid
);

  noc_csr_pkg::access_state_t state_q, state_d;
  noc_csr_pkg::target_sel_t   sel_d, sel_q;   // sel_q held for the resp cycle
  logic [7:0]                 region;         // upper address byte
  logic                       accept;

  // ******************************************************************
  // region decode
  // ******************************************************************
  assign region = req.addr[`AXI_ADDR_WIDTH-1 -: 8];

  always_comb begin : region_dec
    sel_d = noc_csr_pkg::TGT_NONE;
    if (region == `NI_REGION_CSR) begin
      sel_d = noc_csr_pkg::TGT_CSR;      // offset checked inside axi_csr
    end else if (region == `NI_REGION_MBOX) begin
      // single data port, low byte must be zero
      if (req.addr == `NI_MBOX_DATA) sel_d = noc_csr_pkg::TGT_MBOX;
    end
  end

  // ******************************************************************
  // handshake and strobes
  // ******************************************************************
  assign ready  = (state_q == noc_csr_pkg::ST_IDLE);
  assign accept = valid && ready;

  // one strobe at most, only in the acceptance cycle
  assign csr_rd  = accept && (sel_d == noc_csr_pkg::TGT_CSR)  && !req.rd_or_wr;
  assign csr_wr  = accept && (sel_d == noc_csr_pkg::TGT_CSR)  &&  req.rd_or_wr;
  assign mbox_rd = accept && (sel_d == noc_csr_pkg::TGT_MBOX) && !req.rd_or_wr;
  assign mbox_wr = accept && (sel_d == noc_csr_pkg::TGT_MBOX) &&  req.rd_or_wr;

  assign tgt_req = req;  // targets sample it with their strobe

  always_comb begin : next_state
    state_d = state_q;
    unique case (state_q)
      noc_csr_pkg::ST_IDLE: if (accept) state_d = noc_csr_pkg::ST_RESP;
      noc_csr_pkg::ST_RESP: state_d = noc_csr_pkg::ST_IDLE;  // fixed 1 cycle
      default:              state_d = noc_csr_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_axi or posedge arst_axi) begin
    if (arst_axi) begin
      state_q <= noc_csr_pkg::ST_IDLE;
      sel_q   <= noc_csr_pkg::TGT_NONE;
    end else begin
      state_q <= state_d;
      if (accept) sel_q <= sel_d;
    end
  end

  // ******************************************************************
  // response
  // ******************************************************************
  assign rsp_valid = (state_q == noc_csr_pkg::ST_RESP);

  always_comb begin : rsp_mux
    rsp = '0;
    if (rsp_valid) begin
      unique case (sel_q)
        noc_csr_pkg::TGT_CSR:  rsp = csr_rsp;
        noc_csr_pkg::TGT_MBOX: rsp = mbox_rsp;
        default: begin
          rsp.rdata = '0;   // unmapped region
          rsp.error = 1'b1;
        end
      endcase
    end
  end

  // one target strobe per cycle
  a_one_strobe: assert property (@(posedge clk_axi) disable iff (arst_axi)
    $onehot0({csr_rd, csr_wr, mbox_rd, mbox_wr}));

  // every response strobe comes from an acceptance one cycle earlier
  a_rsp_after_accept: assert property (@(posedge clk_axi) disable iff (arst_axi)
    rsp_valid |-> $past(valid && ready));

endmodule

/* logic/axi_csr.sv */
// *********************************************************************
// ni control and status registers
// version, router coordinates, irq mask, mailbox status and irq line
// *********************************************************************
`include "noc_cfg_params.svh"

module axi_csr #(
  parameter int ROUTER_X_ID = 0,
  parameter int ROUTER_Y_ID = 0
) (
  input  logic                     clk_axi,
  input  logic                     arst_axi,
  input  logic                     rd,          // strobe from controller
  input  logic                     wr,
  input  noc_bus_pkg::csr_req_t    req,
  input  noc_csr_pkg::mbox_count_t mbox_count,  // live fill level
  output noc_bus_pkg::csr_rsp_t    rsp,
  output logic                     irq
);

  localparam noc_csr_pkg::router_id_t router_x = noc_csr_pkg::router_id_t'(ROUTER_X_ID);
  localparam noc_csr_pkg::router_id_t router_y = noc_csr_pkg::router_id_t'(ROUTER_Y_ID);

  noc_csr_pkg::irq_mask_t mask_q;
  noc_bus_pkg::csr_rsp_t  rsp_q, rsp_d;
  noc_bus_pkg::axi_data_t dec_data;    // read mux before error gating
  logic                   hit;         // offset is mapped
  logic                   writable;    // only the mask
  logic                   bad_access;
  logic                   irq_q;

  // ******************************************************************
  // offset decode
  // ******************************************************************
  always_comb begin : csr_dec
    dec_data = '0;
    hit      = 1'b1;
    writable = 1'b0;
    case (req.addr)
      `NI_CSR_VERSION:     dec_data = `NI_VERSION_LABEL;
      `NI_CSR_ROUTER_X:    dec_data = noc_bus_pkg::axi_data_t'(router_x);
      `NI_CSR_ROUTER_Y:    dec_data = noc_bus_pkg::axi_data_t'(router_y);
      `NI_CSR_IRQ_MASK: begin
        dec_data = noc_bus_pkg::axi_data_t'(mask_q);
        writable = 1'b1;
      end
      `NI_CSR_MBOX_STATUS: dec_data = noc_bus_pkg::axi_data_t'(mbox_count);
      default:             hit = 1'b0;     // hole in the map
    endcase
  end

  // unmapped offset, or a write to a ro register
  assign bad_access = !hit || (wr && !writable);

  always_comb begin : rsp_build
    rsp_d.error = bad_access;
    rsp_d.rdata = (rd && !bad_access) ? dec_data : '0;  // writes answer zero
  end

  // ******************************************************************
  // registers
  // ******************************************************************

  // response word, loaded on each strobe
  always_ff @(posedge clk_axi) begin
    if (rd || wr) rsp_q <= rsp_d;
  end

  always_ff @(posedge clk_axi or posedge arst_axi) begin
    if (arst_axi) begin
      mask_q <= '0;
      irq_q  <= 1'b0;
    end else begin
      if (wr && !bad_access) mask_q <= req.wdata[0:0];
      irq_q <= mask_q[0] && (mbox_count != '0);  // level, follows 1 cycle late
    end
  end

  assign rsp = rsp_q;
  assign irq = irq_q;

  // controller never strobes both
  a_rd_wr_excl: assert property (@(posedge clk_axi) disable iff (arst_axi)
    !(rd && wr));

endmodule

/* logic/ni_mailbox.sv */
// *********************************************************************
// ni mailbox
// small circular message fifo behind one host data port
// *********************************************************************
`include "noc_cfg_params.svh"

module ni_mailbox (
  input  logic                     clk_axi,
  input  logic                     arst_axi,
  input  logic                     push,    // host write to data port
  input  logic                     pop,     // host read of data port
  input  noc_bus_pkg::axi_data_t   wdata,
  output noc_bus_pkg::csr_rsp_t    rsp,
  output noc_csr_pkg::mbox_count_t count
);

  localparam int depth = `NI_MBOX_DEPTH;
  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;

  noc_bus_pkg::axi_data_t   mem [depth];
  logic [ptr_w-1:0]         wr_ptr_q, rd_ptr_q;
  noc_csr_pkg::mbox_count_t count_q;
  noc_bus_pkg::csr_rsp_t    rsp_q;
  logic                     full, empty;
  logic                     do_push, do_pop;   // legal accesses only

  // wrap at depth, works for any depth
  function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] ptr);
    logic [ptr_w-1:0] nxt;
    nxt = (ptr == ptr_w'(depth - 1)) ? '0 : ptr + 1'b1;
    return nxt;
  endfunction

  assign full    = (count_q == noc_csr_pkg::mbox_count_t'(depth));
  assign empty   = (count_q == '0);
  assign do_push = push && !full;    // overflow drops the word
  assign do_pop  = pop && !empty;

  // ******************************************************************
  // storage and response
  // ******************************************************************
  always_ff @(posedge clk_axi) begin
    if (do_push) mem[wr_ptr_q] <= wdata;
  end

  always_ff @(posedge clk_axi) begin
    if (push || pop) begin
      rsp_q.rdata <= do_pop ? mem[rd_ptr_q] : '0;   // oldest word
      rsp_q.error <= (push && full) || (pop && empty);
    end
  end

  // ******************************************************************
  // pointers and fill level
  // ******************************************************************
  always_ff @(posedge clk_axi or posedge arst_axi) begin
    if (arst_axi) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (do_pop)  rd_ptr_q <= ptr_inc(rd_ptr_q);
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;    // idle, or both at once
      endcase
    end
  end

  assign rsp   = rsp_q;
  assign count = count_q;

  // fill level bounded by the push/pop gating over time
  a_count_bound: assert property (@(posedge clk_axi) disable iff (arst_axi)
    count_q <= noc_csr_pkg::mbox_count_t'(depth));

endmodule

/* logic/ni_csr_top.sv */
// *********************************************************************
// ni register port top level
// access controller with csr block and mailbox
// *********************************************************************

module ni_csr_top #(
  parameter int ROUTER_X_ID = 0,
  parameter int ROUTER_Y_ID = 0
) (
  input  logic                  clk_axi,
  input  logic                  arst_axi,
  input  logic                  valid,
  output logic                  ready,
  input  noc_bus_pkg::csr_req_t req,
  output noc_bus_pkg::csr_rsp_t rsp,
  output logic                  rsp_valid,
  output logic                  irq
);

  noc_bus_pkg::csr_req_t    tgt_req;
  noc_bus_pkg::csr_rsp_t    csr_rsp, mbox_rsp;
  noc_csr_pkg::mbox_count_t mbox_count;        // mailbox to status reg
  logic                     csr_rd, csr_wr;
  logic                     mbox_rd, mbox_wr;

  // decode and response path
  ni_access_ctrl u_ctrl (
    .clk_axi   (clk_axi),
    .arst_axi  (arst_axi),
    .valid     (valid),
    .ready     (ready),
    .req       (req),
    .tgt_req   (tgt_req),
    .csr_rd    (csr_rd),
    .csr_wr    (csr_wr),
    .mbox_rd   (mbox_rd),
    .mbox_wr   (mbox_wr),
    .csr_rsp   (csr_rsp),
    .mbox_rsp  (mbox_rsp),
    .rsp       (rsp),
    .rsp_valid (rsp_valid)
  );

  axi_csr #(
    .ROUTER_X_ID (ROUTER_X_ID),
    .ROUTER_Y_ID (ROUTER_Y_ID)
  ) u_csr (
    .clk_axi    (clk_axi),
    .arst_axi   (arst_axi),
    .rd         (csr_rd),
    .wr         (csr_wr),
    .req        (tgt_req),
    .mbox_count (mbox_count),
    .rsp        (csr_rsp),
    .irq        (irq)
  );

  // write pushes, read pops
  ni_mailbox u_mbox (
    .clk_axi  (clk_axi),
    .arst_axi (arst_axi),
    .push     (mbox_wr),
    .pop      (mbox_rd),
    .wdata    (tgt_req.wdata),
    .rsp      (mbox_rsp),
    .count    (mbox_count)
  );

endmodule

/* verification/tb_ni_csr.sv */
// *********************************************************************
// testbench of the ni register port
// clock, reset, host accesses, reference model and checking assertions
// *********************************************************************
`include "noc_cfg_params.svh"

module tb_ni_csr;

  localparam int router_x   = 3;
  localparam int router_y   = 5;
  localparam int max_cycles = 2000;  // roughly 300 two-cycle accesses at most

  logic                  clk_axi;
  logic                  arst_axi;
  logic                  valid;
  logic                  ready;
  noc_bus_pkg::csr_req_t req;
  noc_bus_pkg::csr_rsp_t rsp;
  logic                  rsp_valid;
  logic                  irq;

  // reference model state
  logic                   model_mask;
  noc_bus_pkg::axi_data_t mbox_q[$];  // mailbox contents with the oldest first
  noc_bus_pkg::csr_rsp_t  exp_rsp;    // expected answer of the access in flight
  logic                   exp_irq;    // irq level implied by the model
  logic                   exp_irq_d;  // irq lags its cause by one cycle
  string                  test_name;
  integer                 seed;
  int                     cycle_cnt;

  ni_csr_top #(
    .ROUTER_X_ID (router_x),
    .ROUTER_Y_ID (router_y)
  ) dut (
    .clk_axi   (clk_axi),
    .arst_axi  (arst_axi),
    .valid     (valid),
    .ready     (ready),
    .req       (req),
    .rsp       (rsp),
    .rsp_valid (rsp_valid),
    .irq       (irq)
  );

  initial clk_axi = 1'b0;
  always #5 clk_axi = ~clk_axi;  // period 10

  // ******************************************************************
  // helpers
  // ******************************************************************
  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Testbench failed");
    $fatal(1, "run stopped at the first error");
  endtask

  // reference model update at acceptance
  task automatic predict(input logic wr, input noc_bus_pkg::axi_addr_t addr,
                         input noc_bus_pkg::axi_data_t wdata);
    noc_bus_pkg::csr_rsp_t  e;
    noc_bus_pkg::axi_data_t rd_val;
    logic                   mapped;
    e      = '0;
    rd_val = '0;
    mapped = 1'b1;
    if (addr[15:8] == `NI_REGION_CSR) begin
      case (addr)
        `NI_CSR_VERSION:     rd_val = 32'h0001_0002;
        `NI_CSR_ROUTER_X:    rd_val = router_x;
        `NI_CSR_ROUTER_Y:    rd_val = router_y;
        `NI_CSR_IRQ_MASK:    rd_val = {31'b0, model_mask};
        `NI_CSR_MBOX_STATUS: rd_val = mbox_q.size();
        default:             mapped = 1'b0;
      endcase
      if (!mapped || (wr && addr != `NI_CSR_IRQ_MASK)) begin
        e.error = 1'b1;  // hole or ro register written
      end else if (wr) begin
        model_mask = wdata[0];
      end else begin
        e.rdata = rd_val;
      end
    end else if (addr == `NI_MBOX_DATA) begin
      if (wr && mbox_q.size() == `NI_MBOX_DEPTH) begin
        e.error = 1'b1;  // overflow
      end else if (wr) begin
        mbox_q.push_back(wdata);
      end else if (mbox_q.size() == 0) begin
        e.error = 1'b1;  // underflow
      end else begin
        e.rdata = mbox_q.pop_front();
      end
    end else begin
      e.error = 1'b1;    // other region or mailbox hole
    end
    exp_rsp = e;
    exp_irq = model_mask && (mbox_q.size() != 0);
  endtask

  // one host access entered and left 1 unit after a rising edge
  task automatic bus_access(input logic wr, input noc_bus_pkg::axi_addr_t addr,
                            input noc_bus_pkg::axi_data_t wdata);
    valid        = 1'b1;
    req.rd_or_wr = wr;
    req.addr     = addr;
    req.wdata    = wr ? wdata : $random(seed);  // junk on reads
    while (!ready) begin
      @(posedge clk_axi);
      #1;
    end
    @(posedge clk_axi);  // accepted on this edge
    #1;
    valid = 1'b0;
    predict(wr, addr, wdata);
    while (!rsp_valid) begin
      @(posedge clk_axi);
      #1;
    end
    @(posedge clk_axi);  // response checked here
    #1;
  endtask

  task automatic reg_read(input noc_bus_pkg::axi_addr_t addr);
    bus_access(1'b0, addr, '0);
  endtask

  task automatic reg_write(input noc_bus_pkg::axi_addr_t addr,
                           input noc_bus_pkg::axi_data_t data);
    bus_access(1'b1, addr, data);
  endtask

  // ******************************************************************
  // checks
  // ******************************************************************
  always @(posedge clk_axi or posedge arst_axi) begin
    if (arst_axi) exp_irq_d <= 1'b0;
    else          exp_irq_d <= exp_irq;
  end

  a_rsp_value: assert property (@(posedge clk_axi) disable iff (arst_axi)
    rsp_valid |-> (rsp == exp_rsp))
    else stop_on_error($sformatf(
      "mismatch in %s: expected rdata %h error %b, actual rdata %h error %b",
      test_name, exp_rsp.rdata, exp_rsp.error, $sampled(rsp.rdata), $sampled(rsp.error)));

  a_rsp_strobe: assert property (@(posedge clk_axi) disable iff (arst_axi)
    (valid && ready) |=> (rsp_valid && !ready) ##1 !rsp_valid)
    else stop_on_error($sformatf(
      "in %s the response strobe after an acceptance was not one cycle with ready low",
      test_name));

  a_no_spurious: assert property (@(posedge clk_axi) disable iff (arst_axi)
    !(valid && ready) |=> !rsp_valid)
    else stop_on_error("rsp_valid went high without an accepted access");

  a_irq_level: assert property (@(posedge clk_axi) disable iff (arst_axi)
    irq == exp_irq_d)
    else stop_on_error($sformatf("mismatch in %s: irq expected %b, actual %b",
      test_name, $sampled(exp_irq_d), $sampled(irq)));

  always @(posedge clk_axi) begin : watchdog
    cycle_cnt++;
    if (cycle_cnt == max_cycles) begin
      stop_on_error($sformatf("timeout, test did not end within %0d cycles", max_cycles));
    end
  end

  // ******************************************************************
  // stimulus
  // ******************************************************************
  initial begin : stimulus
    int n;
    seed       = 91;
    cycle_cnt  = 0;
    valid      = 1'b0;
    req        = '0;
    arst_axi   = 1'b1;
    model_mask = 1'b0;
    exp_rsp    = '0;
    exp_irq    = 1'b0;
    test_name  = "reset";
    repeat (16) @(posedge clk_axi);
    #1;
    arst_axi = 1'b0;

    test_name = "id_regs";
    reg_read(`NI_CSR_VERSION);
    reg_read(`NI_CSR_ROUTER_X);
    reg_read(`NI_CSR_ROUTER_Y);

    test_name = "mask_rw";
    reg_write(`NI_CSR_IRQ_MASK, 32'h0000_0001);
    reg_read(`NI_CSR_IRQ_MASK);
    reg_write(`NI_CSR_VERSION, 32'hdead_beef);  // ro write must fail
    reg_read(`NI_CSR_VERSION);
    reg_write(`NI_CSR_MBOX_STATUS, 32'h0000_0003);
    reg_read(`NI_CSR_MBOX_STATUS);
    reg_write(`NI_CSR_ROUTER_X, 32'h0000_0007);
    reg_read(`NI_CSR_ROUTER_X);

    // random bursts of pushes then pops with a status read after each
    test_name = "mbox_order";
    for (int round = 0; round < 16; round++) begin
      n = 1 + ($unsigned($random(seed)) % `NI_MBOX_DEPTH);
      if (round == 8) reg_write(`NI_CSR_IRQ_MASK, 32'h0);   // irq masked
      if (round == 12) reg_write(`NI_CSR_IRQ_MASK, 32'h1);
      for (int i = 0; i < n; i++) begin
        reg_write(`NI_MBOX_DATA, $random(seed));
        reg_read(`NI_CSR_MBOX_STATUS);
      end
      for (int i = 0; i < n; i++) begin
        reg_read(`NI_MBOX_DATA);
        reg_read(`NI_CSR_MBOX_STATUS);
      end
    end

    test_name = "mbox_errors";
    reg_read(`NI_MBOX_DATA);         // pop from empty
    reg_read(`NI_CSR_MBOX_STATUS);
    for (int i = 0; i < `NI_MBOX_DEPTH; i++) begin
      reg_write(`NI_MBOX_DATA, $random(seed));
    end
    reg_write(`NI_MBOX_DATA, 32'hffff_ffff);  // fifth push
    reg_read(`NI_CSR_MBOX_STATUS);
    for (int i = 0; i < `NI_MBOX_DEPTH; i++) begin
      reg_read(`NI_MBOX_DATA);
    end
    reg_read(`NI_MBOX_DATA);
    reg_read(`NI_CSR_MBOX_STATUS);

    test_name = "unmapped";
    reg_read(16'h0200);
    reg_write(16'h0200, 32'h1234_5678);
    reg_read(16'h0104);
    reg_write(16'h0104, 32'h8765_4321);
    reg_read(16'h0014);
    reg_write(16'h0014, 32'h0000_0001);
    reg_read(`NI_CSR_MBOX_STATUS);     // still empty

    repeat (2) @(posedge clk_axi);
    $display("Testbench passed");
    $finish;
  end

endmodule

/* sim.f */
+incdir+logic
logic/noc_bus_pkg.sv
logic/noc_csr_pkg.sv
logic/ni_access_ctrl.sv
logic/axi_csr.sv
logic/ni_mailbox.sv
logic/ni_csr_top.sv
verification/tb_ni_csr.sv

/* Bender.yml */
package:
  name: ni_csr

sources:
  - include_dirs:
      - logic
    files:
      - logic/noc_bus_pkg.sv
      - logic/noc_csr_pkg.sv
      - logic/ni_access_ctrl.sv
      - logic/axi_csr.sv
      - logic/ni_mailbox.sv
      - logic/ni_csr_top.sv

  - target: test
    include_dirs:
      - logic
    files:
      - verification/tb_ni_csr.sv

export_include_dirs:
  - logic
